/* hdl/axi_pkg.sv */
/*
 * AXI field types and encodings for the write-path data upsizer.
 * Only the fields the converter inspects or forwards are described.
 */
`default_nettype none

package axi_pkg;

  // ------------------------------
  // Field types
  // ------------------------------

  // Burst length minus one
  typedef logic [7:0] len_t;
  // Log2 of bytes per beat
  typedef logic [2:0] size_t;
  typedef logic [1:0] burst_t;
  typedef logic [3:0] cache_t;
  typedef logic [1:0] resp_t;

  // ------------------------------
  // Encodings
  // ------------------------------

  localparam burst_t BURST_INCR = 2'b01;

  // Modifiable bit of the cache attributes
  localparam cache_t CACHE_MODIFIABLE = 4'b0010;

endpackage

`default_nettype wire

/* hdl/upsize_pkg.sv */
/*
 * Converter-level types for the AXI write upsizer.
 * Address and ID widths of the bus, and the write FSM encoding.
 */
`default_nettype none

package upsize_pkg;

  // ------------------------------
  // Bus-level widths
  // ------------------------------

  // Byte address
  typedef logic [31:0] addr_t;

  // Transaction ID, forwarded unchanged
  typedef logic [3:0] id_t;

  // ------------------------------
  // Write FSM
  // ------------------------------

  // W_PASSTHROUGH forwards each narrow beat as its own wide beat,
  // W_UPSIZE packs narrow beats into full wide words
  typedef enum logic [1:0] {
    W_IDLE,
    W_PASSTHROUGH,
    W_UPSIZE
  } w_state_e;

endpackage

`default_nettype wire

/* hdl/aw_burst_calc.sv */
/*
 * Write address burst calculation.
 * Picks pass-through or upsize for an AW request and gives the
 * burst length and size to issue on the wide side.
 */
`default_nettype none

module aw_burst_calc
  import axi_pkg::*;
  import upsize_pkg::*;
#(
  parameter int unsigned WIDE_DATA_W = 64
) (
  input  addr_t  addr_i,
  input  len_t   len_i,
  input  size_t  size_i,
  input  burst_t burst_i,
  input  cache_t cache_i,
  output logic   upsize_o,
  output len_t   wide_len_o,
  output size_t  wide_size_o
);

  localparam int unsigned WIDE_BYTES  = WIDE_DATA_W / 8;
  localparam int unsigned WIDE_OFFS_W = $clog2(WIDE_BYTES);
  localparam addr_t       WIDE_MASK   = addr_t'(WIDE_BYTES - 1);

  addr_t size_mask;
  addr_t addr_start;
  addr_t addr_end;
  addr_t wide_span;

  // Only modifiable INCR bursts may change shape
  assign upsize_o = (|(cache_i & CACHE_MODIFIABLE)) && (burst_i == BURST_INCR);

  always_comb begin
    size_mask  = (addr_t'(1) << size_i) - addr_t'(1);
    addr_start = addr_i & ~WIDE_MASK;
    // Wide word holding the final narrow beat
    addr_end   = ((addr_i & ~size_mask) + (addr_t'(len_i) << size_i)) & ~WIDE_MASK;
    wide_span  = (addr_end - addr_start) >> WIDE_OFFS_W;

    if (upsize_o) begin
      wide_len_o  = len_t'(wide_span);
      wide_size_o = size_t'(WIDE_OFFS_W);
    end else begin
      wide_len_o  = len_i;
      wide_size_o = size_i;
    end
  end

endmodule

`default_nettype wire

/* hdl/w_lane_packer.sv */
/*
 * Write lane packer.
 * Steers the bytes of each narrow W beat onto their wide lanes and
 * accumulates them into the wide beat held for the downstream port.
 */
`default_nettype none

module w_lane_packer
  import axi_pkg::*;
  import upsize_pkg::*;
#(
  parameter int unsigned NARROW_DATA_W = 32,
  parameter int unsigned WIDE_DATA_W   = 64
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       beat_take_i,
  input  addr_t                      beat_addr_i,
  input  size_t                      beat_size_i,
  input  logic                       flush_i,
  input  logic                       last_i,
  input  logic [NARROW_DATA_W-1:0]   w_data_i,
  input  logic [NARROW_DATA_W/8-1:0] w_strb_i,
  input  logic                       mst_w_ready_i,
  output logic                       wide_valid_o,
  output logic [WIDE_DATA_W-1:0]     mst_w_data_o,
  output logic [WIDE_DATA_W/8-1:0]   mst_w_strb_o,
  output logic                       mst_w_last_o
);

  localparam int unsigned NARROW_BYTES = NARROW_DATA_W / 8;
  localparam int unsigned WIDE_BYTES   = WIDE_DATA_W / 8;

  logic [WIDE_DATA_W-1:0]   data_q, data_d;
  logic [WIDE_BYTES-1:0]    strb_q, strb_d;
  logic                     valid_q;
  logic                     last_q;
  logic                     accept;
  int unsigned              wide_offs;
  int unsigned              narrow_offs;
  int unsigned              beat_bytes;
  int unsigned              block_offs;

  assign accept = valid_q && mst_w_ready_i;

  // ------------------------------
  // Lane steering
  // ------------------------------

  always_comb begin
    wide_offs   = int'(beat_addr_i & addr_t'(WIDE_BYTES - 1));
    narrow_offs = int'(beat_addr_i & addr_t'(NARROW_BYTES - 1));
    beat_bytes  = 1 << beat_size_i;
    // Offset of the beat address inside its size block
    block_offs  = int'(beat_addr_i & addr_t'(beat_bytes - 1));

    data_d = accept ? '0 : data_q;
    strb_d = accept ? '0 : strb_q;

    if (beat_take_i) begin
      for (int b = 0; b < WIDE_BYTES; b++) begin
        // Lane b receives narrow byte b - wide_offs + narrow_offs
        if ((b >= wide_offs) && (b - wide_offs < beat_bytes - block_offs) &&
            (b + narrow_offs - wide_offs < NARROW_BYTES)) begin
          data_d[8*b +: 8] = w_data_i[8*(b + narrow_offs - wide_offs) +: 8];
          strb_d[b]        = w_strb_i[b + narrow_offs - wide_offs];
        end
      end
    end
  end

  // ------------------------------
  // Held wide beat
  // ------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      last_q  <= 1'b0;
      data_q  <= '0;
      strb_q  <= '0;
    end else begin
      data_q <= data_d;
      strb_q <= strb_d;
      if (accept) begin
        valid_q <= 1'b0;
        last_q  <= 1'b0;
      end
      if (beat_take_i) begin
        last_q <= last_i;
        if (flush_i) begin
          valid_q <= 1'b1;
        end
      end
    end
  end

  assign wide_valid_o = valid_q;
  assign mst_w_data_o = data_q;
  assign mst_w_strb_o = strb_q;
  assign mst_w_last_o = last_q;

endmodule

`default_nettype wire

/* hdl/w_upsize_ctrl.sv */
/*
 * Write control FSM of the upsizer.
 * Holds the downstream AW request, walks the narrow beat address and
 * tells the packer when a wide beat is complete.
 */
`default_nettype none

module w_upsize_ctrl
  import axi_pkg::*;
  import upsize_pkg::*;
#(
  parameter int unsigned NARROW_DATA_W = 32,
  parameter int unsigned WIDE_DATA_W   = 64
) (
  input  logic   clk_i,
  input  logic   rst_ni,
  // Upstream AW and its burst calculation
  input  logic   aw_valid_i,
  input  id_t    aw_id_i,
  input  addr_t  aw_addr_i,
  input  len_t   aw_len_i,
  input  size_t  aw_size_i,
  input  burst_t aw_burst_i,
  input  cache_t aw_cache_i,
  input  logic   upsize_i,
  input  len_t   wide_len_i,
  input  size_t  wide_size_i,
  output logic   aw_ready_o,
  // Downstream AW
  output id_t    mst_aw_id_o,
  output addr_t  mst_aw_addr_o,
  output len_t   mst_aw_len_o,
  output size_t  mst_aw_size_o,
  output burst_t mst_aw_burst_o,
  output cache_t mst_aw_cache_o,
  output logic   mst_aw_valid_o,
  input  logic   mst_aw_ready_i,
  // W flow
  input  logic   w_valid_i,
  input  logic   wide_valid_i,
  input  logic   mst_w_ready_i,
  output logic   w_ready_o,
  output logic   beat_take_o,
  output addr_t  beat_addr_o,
  output size_t  beat_size_o,
  output logic   flush_o,
  output logic   last_o
);

  localparam int unsigned NARROW_BYTES = NARROW_DATA_W / 8;
  localparam int unsigned WIDE_BYTES   = WIDE_DATA_W / 8;
  localparam size_t       NARROW_SIZE  = size_t'($clog2(NARROW_BYTES));
  localparam addr_t       WIDE_MASK    = addr_t'(WIDE_BYTES - 1);

  w_state_e state_q, state_d;
  logic     aw_valid_q, aw_valid_d;
  logic     done_q, done_d;
  addr_t    beat_addr_q;
  len_t     beat_cnt_q;
  size_t    beat_size_q;
  addr_t    size_mask;
  addr_t    next_addr;
  logic     aw_take;
  logic     wide_accept;
  logic     word_change;

  // ------------------------------
  // Handshakes
  // ------------------------------

  assign aw_ready_o  = (state_q == W_IDLE);
  assign aw_take     = aw_valid_i && aw_ready_o;
  assign wide_accept = wide_valid_i && mst_w_ready_i;

  // W opens once the address is out, and only if the held beat can move
  assign w_ready_o   = (state_q != W_IDLE) && !aw_valid_q && !done_q &&
                       (!wide_valid_i || mst_w_ready_i);
  assign beat_take_o = w_valid_i && w_ready_o;

  // ------------------------------
  // Beat address walk
  // ------------------------------

  assign size_mask   = (addr_t'(1) << beat_size_q) - addr_t'(1);
  assign next_addr   = (beat_addr_q & ~size_mask) + (addr_t'(1) << beat_size_q);
  assign word_change = (next_addr & ~WIDE_MASK) != (beat_addr_q & ~WIDE_MASK);

  assign last_o      = (beat_cnt_q == '0);
  assign flush_o     = (state_q == W_PASSTHROUGH) ||
                       ((state_q == W_UPSIZE) && (last_o || word_change));
  assign beat_addr_o = beat_addr_q;
  assign beat_size_o = beat_size_q;

  // ------------------------------
  // FSM
  // ------------------------------

  always_comb begin
    state_d    = state_q;
    aw_valid_d = aw_valid_q;
    done_d     = done_q;

    case (state_q)
      W_IDLE: begin
        if (aw_take) begin
          state_d    = upsize_i ? W_UPSIZE : W_PASSTHROUGH;
          aw_valid_d = 1'b1;
          done_d     = 1'b0;
        end
      end
      default: begin
        if (aw_valid_q && mst_aw_ready_i) begin
          aw_valid_d = 1'b0;
        end
        if (beat_take_o && last_o) begin
          done_d = 1'b1;
        end
        // Any wide beat leaving after the final narrow beat is the last one
        if (done_q && wide_accept) begin
          state_d = W_IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= W_IDLE;
      aw_valid_q <= 1'b0;
      done_q     <= 1'b0;
    end else begin
      state_q    <= state_d;
      aw_valid_q <= aw_valid_d;
      done_q     <= done_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_take) begin
      mst_aw_id_o    <= aw_id_i;
      mst_aw_addr_o  <= aw_addr_i;
      mst_aw_len_o   <= wide_len_i;
      mst_aw_size_o  <= wide_size_i;
      mst_aw_burst_o <= aw_burst_i;
      mst_aw_cache_o <= aw_cache_i;
      beat_addr_q    <= aw_addr_i;
      beat_cnt_q     <= aw_len_i;
      // A narrow beat never spans more than the narrow bus
      beat_size_q    <= (aw_size_i > NARROW_SIZE) ? NARROW_SIZE : aw_size_i;
    end else if (beat_take_o) begin
      beat_addr_q <= next_addr;
      beat_cnt_q  <= beat_cnt_q - len_t'(1);
    end
  end

  assign mst_aw_valid_o = aw_valid_q;

endmodule

`default_nettype wire

/* hdl/axi_w_upsize.sv */
/*
 * AXI write-path data upsizer.
 * Connects a narrow write master to a wide slave, packing modifiable
 * INCR bursts into full wide beats. B passes straight back.
 */
`default_nettype none

module axi_w_upsize
  import axi_pkg::*;
  import upsize_pkg::*;
#(
  parameter int unsigned NARROW_DATA_W = 32,
  parameter int unsigned WIDE_DATA_W   = 64
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // Upstream, narrow side
  input  id_t                        slv_aw_id_i,
  input  addr_t                      slv_aw_addr_i,
  input  len_t                       slv_aw_len_i,
  input  size_t                      slv_aw_size_i,
  input  burst_t                     slv_aw_burst_i,
  input  cache_t                     slv_aw_cache_i,
  input  logic                       slv_aw_valid_i,
  output logic                       slv_aw_ready_o,
  input  logic [NARROW_DATA_W-1:0]   slv_w_data_i,
  input  logic [NARROW_DATA_W/8-1:0] slv_w_strb_i,
  input  logic                       slv_w_last_i,
  input  logic                       slv_w_valid_i,
  output logic                       slv_w_ready_o,
  output id_t                        slv_b_id_o,
  output resp_t                      slv_b_resp_o,
  output logic                       slv_b_valid_o,
  input  logic                       slv_b_ready_i,
  // Downstream, wide side
  output id_t                        mst_aw_id_o,
  output addr_t                      mst_aw_addr_o,
  output len_t                       mst_aw_len_o,
  output size_t                      mst_aw_size_o,
  output burst_t                     mst_aw_burst_o,
  output cache_t                     mst_aw_cache_o,
  output logic                       mst_aw_valid_o,
  input  logic                       mst_aw_ready_i,
  output logic [WIDE_DATA_W-1:0]     mst_w_data_o,
  output logic [WIDE_DATA_W/8-1:0]   mst_w_strb_o,
  output logic                       mst_w_last_o,
  output logic                       mst_w_valid_o,
  input  logic                       mst_w_ready_i,
  input  id_t                        mst_b_id_i,
  input  resp_t                      mst_b_resp_i,
  input  logic                       mst_b_valid_i,
  output logic                       mst_b_ready_o
);

  logic  upsize;
  len_t  wide_len;
  size_t wide_size;
  logic  beat_take;
  addr_t beat_addr;
  size_t beat_size;
  logic  flush;
  logic  last;
  logic  wide_valid;

  aw_burst_calc #(
    .WIDE_DATA_W (WIDE_DATA_W)
  ) i_aw_burst_calc (
    .addr_i      (slv_aw_addr_i),
    .len_i       (slv_aw_len_i),
    .size_i      (slv_aw_size_i),
    .burst_i     (slv_aw_burst_i),
    .cache_i     (slv_aw_cache_i),
    .upsize_o    (upsize),
    .wide_len_o  (wide_len),
    .wide_size_o (wide_size)
  );

  w_upsize_ctrl #(
    .NARROW_DATA_W (NARROW_DATA_W),
    .WIDE_DATA_W   (WIDE_DATA_W)
  ) i_w_upsize_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .aw_valid_i     (slv_aw_valid_i),
    .aw_id_i        (slv_aw_id_i),
    .aw_addr_i      (slv_aw_addr_i),
    .aw_len_i       (slv_aw_len_i),
    .aw_size_i      (slv_aw_size_i),
    .aw_burst_i     (slv_aw_burst_i),
    .aw_cache_i     (slv_aw_cache_i),
    .upsize_i       (upsize),
    .wide_len_i     (wide_len),
    .wide_size_i    (wide_size),
    .aw_ready_o     (slv_aw_ready_o),
    .mst_aw_id_o    (mst_aw_id_o),
    .mst_aw_addr_o  (mst_aw_addr_o),
    .mst_aw_len_o   (mst_aw_len_o),
    .mst_aw_size_o  (mst_aw_size_o),
    .mst_aw_burst_o (mst_aw_burst_o),
    .mst_aw_cache_o (mst_aw_cache_o),
    .mst_aw_valid_o (mst_aw_valid_o),
    .mst_aw_ready_i (mst_aw_ready_i),
    .w_valid_i      (slv_w_valid_i),
    .wide_valid_i   (wide_valid),
    .mst_w_ready_i  (mst_w_ready_i),
    .w_ready_o      (slv_w_ready_o),
    .beat_take_o    (beat_take),
    .beat_addr_o    (beat_addr),
    .beat_size_o    (beat_size),
    .flush_o        (flush),
    .last_o         (last)
  );

  // Burst end comes from the beat count, so slv_w_last_i carries no extra information
  w_lane_packer #(
    .NARROW_DATA_W (NARROW_DATA_W),
    .WIDE_DATA_W   (WIDE_DATA_W)
  ) i_w_lane_packer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .beat_take_i   (beat_take),
    .beat_addr_i   (beat_addr),
    .beat_size_i   (beat_size),
    .flush_i       (flush),
    .last_i        (last),
    .w_data_i      (slv_w_data_i),
    .w_strb_i      (slv_w_strb_i),
    .mst_w_ready_i (mst_w_ready_i),
    .wide_valid_o  (wide_valid),
    .mst_w_data_o  (mst_w_data_o),
    .mst_w_strb_o  (mst_w_strb_o),
    .mst_w_last_o  (mst_w_last_o)
  );

  assign mst_w_valid_o = wide_valid;

  // ------------------------------
  // B channel, no latency
  // ------------------------------

  assign slv_b_id_o    = mst_b_id_i;
  assign slv_b_resp_o  = mst_b_resp_i;
  assign slv_b_valid_o = mst_b_valid_i;
  assign mst_b_ready_o = slv_b_ready_i;

endmodule

`default_nettype wire

/* tests/tb_axi_w_upsize.sv */
/*
 * Testbench for the AXI write upsizer.
 * Drives narrow write bursts with random downstream ready, predicts the
 * wide AW and W traffic from byte addresses and checks every handshake.
 */
`default_nettype none

module tb_axi_w_upsize
  import axi_pkg::*;
  import upsize_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned NARROW_DATA_W = 32;
  localparam int unsigned WIDE_DATA_W   = 64;
  localparam int unsigned NB            = NARROW_DATA_W / 8;
  localparam int unsigned WB            = WIDE_DATA_W / 8;
  localparam int unsigned N_RANDOM      = 40;
  // 50 bursts of up to 16 beats at about 3 cycles per beat, plus margin
  localparam int unsigned TIMEOUT_CYCLES = 4000;

  typedef logic [NARROW_DATA_W-1:0] ndata_t;
  typedef logic [NB-1:0]            nstrb_t;

  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
    cache_t cache;
  } aw_exp_t;

  typedef struct packed {
    logic [WIDE_DATA_W-1:0] data;
    logic [WB-1:0]          strb;
    logic                   last;
  } w_exp_t;

  logic clk_i;
  logic rst_ni;
  id_t slv_aw_id_i;
  addr_t slv_aw_addr_i;
  len_t slv_aw_len_i;
  size_t slv_aw_size_i;
  burst_t slv_aw_burst_i;
  cache_t slv_aw_cache_i;
  logic slv_aw_valid_i, slv_aw_ready_o;
  ndata_t slv_w_data_i;
  nstrb_t slv_w_strb_i;
  logic slv_w_last_i, slv_w_valid_i, slv_w_ready_o;
  id_t slv_b_id_o;
  resp_t slv_b_resp_o;
  logic slv_b_valid_o, slv_b_ready_i;
  id_t mst_aw_id_o;
  addr_t mst_aw_addr_o;
  len_t mst_aw_len_o;
  size_t mst_aw_size_o;
  burst_t mst_aw_burst_o;
  cache_t mst_aw_cache_o;
  logic mst_aw_valid_o, mst_aw_ready_i;
  logic [WIDE_DATA_W-1:0] mst_w_data_o;
  logic [WB-1:0] mst_w_strb_o;
  logic mst_w_last_o, mst_w_valid_o, mst_w_ready_i;
  id_t mst_b_id_i;
  resp_t mst_b_resp_i;
  logic mst_b_valid_i, mst_b_ready_o;

  integer seed;
  integer ready_seed;
  int unsigned cycle_cnt;
  int unsigned w_beats;
  aw_exp_t exp_aw_q [$];
  w_exp_t exp_w_q [$];
  len_t got_len_q [$];
  aw_exp_t mon_aw;
  w_exp_t mon_w;
  len_t mon_len;

  axi_w_upsize #(
    .NARROW_DATA_W (NARROW_DATA_W),
    .WIDE_DATA_W   (WIDE_DATA_W)
  ) DUT (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .slv_aw_id_i    (slv_aw_id_i),
    .slv_aw_addr_i  (slv_aw_addr_i),
    .slv_aw_len_i   (slv_aw_len_i),
    .slv_aw_size_i  (slv_aw_size_i),
    .slv_aw_burst_i (slv_aw_burst_i),
    .slv_aw_cache_i (slv_aw_cache_i),
    .slv_aw_valid_i (slv_aw_valid_i),
    .slv_aw_ready_o (slv_aw_ready_o),
    .slv_w_data_i   (slv_w_data_i),
    .slv_w_strb_i   (slv_w_strb_i),
    .slv_w_last_i   (slv_w_last_i),
    .slv_w_valid_i  (slv_w_valid_i),
    .slv_w_ready_o  (slv_w_ready_o),
    .slv_b_id_o     (slv_b_id_o),
    .slv_b_resp_o   (slv_b_resp_o),
    .slv_b_valid_o  (slv_b_valid_o),
    .slv_b_ready_i  (slv_b_ready_i),
    .mst_aw_id_o    (mst_aw_id_o),
    .mst_aw_addr_o  (mst_aw_addr_o),
    .mst_aw_len_o   (mst_aw_len_o),
    .mst_aw_size_o  (mst_aw_size_o),
    .mst_aw_burst_o (mst_aw_burst_o),
    .mst_aw_cache_o (mst_aw_cache_o),
    .mst_aw_valid_o (mst_aw_valid_o),
    .mst_aw_ready_i (mst_aw_ready_i),
    .mst_w_data_o   (mst_w_data_o),
    .mst_w_strb_o   (mst_w_strb_o),
    .mst_w_last_o   (mst_w_last_o),
    .mst_w_valid_o  (mst_w_valid_o),
    .mst_w_ready_i  (mst_w_ready_i),
    .mst_b_id_i     (mst_b_id_i),
    .mst_b_resp_i   (mst_b_resp_i),
    .mst_b_valid_i  (mst_b_valid_i),
    .mst_b_ready_o  (mst_b_ready_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    assert (got === exp) else begin
      $display("error: %s got 0x%h expected 0x%h", name, got, exp);
      stop_with_failure("value mismatch on the DUT outputs");
    end
  endtask

  // ------------------------------
  // Reference model and driver
  // ------------------------------

  task automatic send_burst(input id_t id, input addr_t addr, input len_t len,
                            input size_t size, input burst_t burst, input cache_t cache);
    ndata_t  beat_data [$];
    nstrb_t  beat_strb [$];
    aw_exp_t aw;
    w_exp_t  wb;
    logic    upsize;
    addr_t   baddr;
    addr_t   aligned;
    addr_t   nxt;
    addr_t   last_word;
    ndata_t  d;
    nstrb_t  lanes;
    nstrb_t  s;
    upsize    = ((cache & CACHE_MODIFIABLE) != '0) && (burst == BURST_INCR);
    aw        = '{id, addr, len, size, burst, cache};
    baddr     = addr;
    last_word = addr / WB;
    wb        = '0;
    for (int i = 0; i <= int'(len); i++) begin
      aligned = baddr & ~((addr_t'(1) << size) - addr_t'(1));
      nxt     = aligned + (addr_t'(1) << size);
      lanes   = '0;
      // Valid bytes run from the beat address to the end of its size block
      for (addr_t a = baddr; a < nxt; a++) begin
        lanes[a % NB] = 1'b1;
      end
      d = ndata_t'($random(seed));
      s = nstrb_t'($random(seed)) & lanes;
      for (addr_t a = baddr; a < nxt; a++) begin
        wb.data[8*(a % WB) +: 8] = d[8*(a % NB) +: 8];
        wb.strb[a % WB]          = s[a % NB];
      end
      beat_data.push_back(d);
      beat_strb.push_back(s);
      last_word = baddr / WB;
      if (!upsize || (i == int'(len)) || ((nxt / WB) != (baddr / WB))) begin
        wb.last = (i == int'(len));
        exp_w_q.push_back(wb);
        wb = '0;
      end
      baddr = nxt;
    end
    if (upsize) begin
      aw.len  = len_t'(last_word - addr / WB);
      aw.size = size_t'($clog2(WB));
    end
    exp_aw_q.push_back(aw);

    @(negedge clk_i);
    slv_aw_id_i    = id;
    slv_aw_addr_i  = addr;
    slv_aw_len_i   = len;
    slv_aw_size_i  = size;
    slv_aw_burst_i = burst;
    slv_aw_cache_i = cache;
    slv_aw_valid_i = 1'b1;
    do @(posedge clk_i); while (!slv_aw_ready_o);
    @(negedge clk_i);
    slv_aw_valid_i = 1'b0;
    for (int i = 0; i <= int'(len); i++) begin
      while (($random(seed) & 7) == 0) @(negedge clk_i);
      slv_w_data_i  = beat_data.pop_front();
      slv_w_strb_i  = beat_strb.pop_front();
      slv_w_last_i  = (i == int'(len));
      slv_w_valid_i = 1'b1;
      do @(posedge clk_i); while (!slv_w_ready_o);
      @(negedge clk_i);
      slv_w_valid_i = 1'b0;
    end
  endtask

  task automatic random_burst();
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
    cache_t cache;
    id    = id_t'($random(seed));
    cache = cache_t'($random(seed));
    burst = (($random(seed) & 3) == 0) ? burst_t'(($random(seed) & 1) << 1) : BURST_INCR;
    size  = size_t'($random(seed) & 3);
    if (size == 3'd3) size = 3'd2;
    // Non-INCR bursts stay single beat
    len   = (burst == BURST_INCR) ? len_t'($random(seed) & 15) : len_t'(0);
    addr  = addr_t'($random(seed) & 32'h0000_ffff);
    if (size != 3'd2) addr = addr & ~((addr_t'(1) << size) - addr_t'(1));
    send_burst(id, addr, len, size, burst, cache);
  endtask

  // Ready and B stimulus, independent of the burst driver
  always @(negedge clk_i) begin
    if (rst_ni) begin
      mst_aw_ready_i = ($random(ready_seed) & 3) != 0;
      mst_w_ready_i  = ($random(ready_seed) & 3) != 0;
      mst_b_id_i     = id_t'($random(ready_seed));
      mst_b_resp_i   = resp_t'($random(ready_seed));
      mst_b_valid_i  = ($random(ready_seed) & 1) != 0;
      slv_b_ready_i  = ($random(ready_seed) & 1) != 0;
    end
  end

  // ------------------------------
  // Checks
  // ------------------------------

  always @(posedge clk_i) begin
    if (rst_ni) begin
      compare_value("slv_b_id_o", slv_b_id_o, mst_b_id_i);
      compare_value("slv_b_resp_o", slv_b_resp_o, mst_b_resp_i);
      compare_value("slv_b_valid_o", slv_b_valid_o, mst_b_valid_i);
      compare_value("mst_b_ready_o", mst_b_ready_o, slv_b_ready_i);
      if (mst_aw_valid_o && mst_aw_ready_i) begin
        if (exp_aw_q.size() == 0) begin
          stop_with_failure("downstream AW appeared with no request pending");
        end else begin
          mon_aw = exp_aw_q.pop_front();
          compare_value("mst_aw_id_o", mst_aw_id_o, mon_aw.id);
          compare_value("mst_aw_addr_o", mst_aw_addr_o, mon_aw.addr);
          compare_value("mst_aw_len_o", mst_aw_len_o, mon_aw.len);
          compare_value("mst_aw_size_o", mst_aw_size_o, mon_aw.size);
          compare_value("mst_aw_burst_o", mst_aw_burst_o, mon_aw.burst);
          compare_value("mst_aw_cache_o", mst_aw_cache_o, mon_aw.cache);
          got_len_q.push_back(mon_aw.len);
        end
      end
      if (mst_w_valid_o && mst_w_ready_i) begin
        if (exp_w_q.size() == 0 || got_len_q.size() == 0) begin
          stop_with_failure("downstream W beat appeared with none expected");
        end else begin
          mon_w = exp_w_q.pop_front();
          compare_value("mst_w_data_o", mst_w_data_o, mon_w.data);
          compare_value("mst_w_strb_o", mst_w_strb_o, mon_w.strb);
          compare_value("mst_w_last_o", mst_w_last_o, mon_w.last);
          w_beats = w_beats + 1;
          if (mst_w_last_o) begin
            mon_len = got_len_q.pop_front();
            compare_value("mst_w_last_o beat count", w_beats, mon_len + 1);
            w_beats = 0;
          end
        end
      end
    end
  end

  // Payload holds while valid waits for ready
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mst_w_valid_o && !mst_w_ready_i) |=>
      (mst_w_valid_o && $stable({mst_w_data_o, mst_w_strb_o, mst_w_last_o})))
    else stop_with_failure("downstream W beat changed while it waited for ready");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mst_aw_valid_o && !mst_aw_ready_i) |=>
      (mst_aw_valid_o && $stable({mst_aw_id_o, mst_aw_addr_o, mst_aw_len_o,
                                  mst_aw_size_o, mst_aw_burst_o, mst_aw_cache_o})))
    else stop_with_failure("downstream AW changed while it waited for ready");

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      stop_with_failure($sformatf("timeout: run did not finish in %0d cycles", TIMEOUT_CYCLES));
    end
  end

  // ------------------------------
  // Test sequence
  // ------------------------------

  initial begin
    seed           = 10147;
    ready_seed     = 10147;
    cycle_cnt      = 0;
    w_beats        = 0;
    rst_ni         = 1'b0;
    slv_aw_id_i    = '0;
    slv_aw_addr_i  = '0;
    slv_aw_len_i   = '0;
    slv_aw_size_i  = '0;
    slv_aw_burst_i = '0;
    slv_aw_cache_i = '0;
    slv_aw_valid_i = 1'b0;
    slv_w_data_i   = '0;
    slv_w_strb_i   = '0;
    slv_w_last_i   = 1'b0;
    slv_w_valid_i  = 1'b0;
    slv_b_ready_i  = 1'b0;
    mst_aw_ready_i = 1'b0;
    mst_w_ready_i  = 1'b0;
    mst_b_id_i     = '0;
    mst_b_resp_i   = '0;
    mst_b_valid_i  = 1'b0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    compare_value("slv_aw_ready_o", slv_aw_ready_o, 1);
    compare_value("slv_w_ready_o", slv_w_ready_o, 0);
    compare_value("mst_aw_valid_o", mst_aw_valid_o, 0);
    compare_value("mst_w_valid_o", mst_w_valid_o, 0);
    rst_ni = 1'b1;

    // Pass-through: non-modifiable INCR, FIXED and WRAP
    send_burst(4'h1, 32'h0000_0100, 8'd3, 3'd2, BURST_INCR, 4'h0);
    send_burst(4'h2, 32'h0000_0105, 8'd2, 3'd2, BURST_INCR, 4'h1);
    send_burst(4'h3, 32'h0000_0204, 8'd0, 3'd2, 2'b00, 4'h2);
    send_burst(4'h4, 32'h0000_030a, 8'd0, 3'd1, 2'b10, 4'h3);
    send_burst(4'h9, 32'h0000_0901, 8'd2, 3'd1, BURST_INCR, 4'h0);
    // Upsize: aligned, unaligned and sub-word beats
    send_burst(4'h5, 32'h0000_0400, 8'd7, 3'd2, BURST_INCR, 4'h2);
    send_burst(4'h6, 32'h0000_0503, 8'd4, 3'd2, BURST_INCR, 4'hf);
    send_burst(4'h7, 32'h0000_0610, 8'd9, 3'd0, BURST_INCR, 4'h2);
    send_burst(4'h8, 32'h0000_0706, 8'd5, 3'd1, BURST_INCR, 4'h3);
    send_burst(4'ha, 32'h0000_0801, 8'd6, 3'd1, BURST_INCR, 4'h2);

    for (int t = 0; t < N_RANDOM; t++) begin
      random_burst();
    end

    while ((exp_aw_q.size() != 0) || (exp_w_q.size() != 0)) begin
      @(posedge clk_i);
    end
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
hdl/axi_pkg.sv
hdl/upsize_pkg.sv
hdl/aw_burst_calc.sv
hdl/w_lane_packer.sv
hdl/w_upsize_ctrl.sv
hdl/axi_w_upsize.sv
tests/tb_axi_w_upsize.sv

/* run_sim.sh */
#!/bin/sh
# Build the upsizer testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_axi_w_upsize -f sim.f
./obj_dir/Vtb_axi_w_upsize 2>&1 | tee sim.log

if grep -q "Done: errors found" sim.log; then
  echo "simulation failed"
  exit 1
fi
grep -q "Done: no errors" sim.log
echo "simulation passed"
